/* vlog.f */
rtl/snoopPkg.sv
rtl/accessDecode.sv
rtl/wramTracker.sv
rtl/vramTracker.sv
rtl/paletteSpriteTracker.sv
rtl/mirrorRequest.sv
rtl/contextSnoop.sv
test/contextSnoopTb.sv

/* test/contextSnoopTb.sv */
`timescale 1ns/1ps

module contextSnoopTb;

  localparam snoopPkg::busAddrT mirrorBase = 24'hF50000;
  localparam int numRows = 24;
  localparam int timeoutCycles = 20 * numRows + 50;
  localparam int cpuWr = 0;
  localparam int paWr = 1;
  localparam int paRd = 2;

  logic              clkin;
  logic              reset;
  snoopPkg::busAddrT snesAddr;
  snoopPkg::byteT    snesPa;
  snoopPkg::byteT    snesData;
  logic              wrStrobe;
  logic              paRdStrobe;
  logic              paWrStrobe;
  logic              busRdy;
  logic              busWrq;
  snoopPkg::busAddrT romAddr;
  snoopPkg::romDataT romData;
  logic              romWordEnable;

  // stimulus table with expected addresses relative to mirror base
  int                rowKind [numRows];
  snoopPkg::busAddrT rowAddr [numRows];
  snoopPkg::byteT    rowPa [numRows];
  snoopPkg::byteT    rowData [numRows];
  logic              rowStall [numRows];
  logic              expReq [numRows];
  snoopPkg::busAddrT expOffset [numRows];
  snoopPkg::romDataT expData [numRows];
  logic              expWord [numRows];

  int     rowCount = 0;
  int     curRow = 0;
  int     errorCount = 0;
  int     passCount = 0;
  int     cycleCount = 0;
  integer seed = 32'h89852844;

  contextSnoop #(.mirrorBase(mirrorBase)) contextSnoop_inst (
    .clkin(clkin), .reset(reset), .snesAddr(snesAddr), .snesPa(snesPa),
    .snesData(snesData), .wrStrobe(wrStrobe), .paRdStrobe(paRdStrobe),
    .paWrStrobe(paWrStrobe), .busRdy(busRdy), .busWrq(busWrq), .romAddr(romAddr),
    .romData(romData), .romWordEnable(romWordEnable)
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  always @(posedge clkin) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", timeoutCycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic checkAddr(input snoopPkg::busAddrT got, input snoopPkg::busAddrT exp,
                           input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: row %0d %s got %h expected %h",
               $time, curRow, msg, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkData(input snoopPkg::romDataT got, input snoopPkg::romDataT exp,
                           input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: row %0d %s got %h expected %h",
               $time, curRow, msg, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: row %0d %s got %b expected %b",
               $time, curRow, msg, got, exp);
      errorCount++;
    end
  endtask

  task automatic addRow(input int kind, input snoopPkg::busAddrT addr,
                        input snoopPkg::byteT pa, input snoopPkg::byteT data,
                        input logic stall, input logic req, input snoopPkg::busAddrT offs,
                        input snoopPkg::romDataT word, input logic wordEn);
    rowKind[rowCount]   = kind;
    rowAddr[rowCount]   = addr;
    rowPa[rowCount]     = pa;
    rowData[rowCount]   = data;
    rowStall[rowCount]  = stall;
    expReq[rowCount]    = req;
    expOffset[rowCount] = offs;
    expData[rowCount]   = word;
    expWord[rowCount]   = wordEn;
    rowCount++;
  endtask

  task automatic buildTable();
    // WRAM bank and shadow writes
    addRow(cpuWr, 24'h7E1234, 8'hFF, 8'hA5, 1'b0, 1'b1, 24'h001234, 16'hA5A5, 1'b0);
    addRow(cpuWr, 24'h000123, 8'hFF, 8'h3C, 1'b0, 1'b1, 24'h000123, 16'h3C3C, 1'b0);
    // WRAM port pointer then two data writes
    addRow(paWr, 24'h002181, 8'h81, 8'h10, 1'b0, 1'b1, 24'h040602, 16'h1010, 1'b1);
    addRow(paWr, 24'h002182, 8'h82, 8'h00, 1'b0, 1'b1, 24'h040604, 16'h0000, 1'b1);
    addRow(paWr, 24'h002183, 8'h83, 8'h00, 1'b0, 1'b1, 24'h040606, 16'h0000, 1'b1);
    addRow(paWr, 24'h002180, 8'h80, 8'h77, 1'b0, 1'b1, 24'h000010, 16'h7777, 1'b0);
    addRow(paWr, 24'h002180, 8'h80, 8'h88, 1'b0, 1'b1, 24'h000011, 16'h8888, 1'b0);
    // VRAM mode 0, pointer 0x0100, low then high data port
    addRow(paWr, 24'h002115, 8'h15, 8'h00, 1'b0, 1'b1, 24'h04052A, 16'h0000, 1'b1);
    addRow(paWr, 24'h002116, 8'h16, 8'h00, 1'b0, 1'b1, 24'h04052C, 16'h0000, 1'b1);
    addRow(paWr, 24'h002117, 8'h17, 8'h01, 1'b0, 1'b1, 24'h04052E, 16'h0101, 1'b1);
    addRow(paWr, 24'h002118, 8'h18, 8'h11, 1'b0, 1'b1, 24'h020200, 16'h1111, 1'b0);
    addRow(paWr, 24'h002119, 8'h19, 8'h22, 1'b0, 1'b1, 24'h020203, 16'h2222, 1'b0);
    // CGRAM with the first data write stalled on the bus
    addRow(paWr, 24'h002121, 8'h21, 8'h05, 1'b0, 1'b1, 24'h040542, 16'h0505, 1'b1);
    addRow(paWr, 24'h002122, 8'h22, 8'h5A, 1'b1, 1'b1, 24'h04000A, 16'h5A5A, 1'b0);
    addRow(paWr, 24'h002122, 8'h22, 8'h6B, 1'b0, 1'b1, 24'h04000B, 16'h6B6B, 1'b0);
    // OAM low table then high table at 0x206
    addRow(paWr, 24'h002102, 8'h02, 8'h03, 1'b0, 1'b1, 24'h040504, 16'h0303, 1'b1);
    addRow(paWr, 24'h002104, 8'h04, 8'h99, 1'b0, 1'b1, 24'h040206, 16'h9999, 1'b0);
    addRow(paWr, 24'h002103, 8'h03, 8'h01, 1'b0, 1'b1, 24'h040506, 16'h0101, 1'b1);
    addRow(paWr, 24'h002104, 8'h04, 8'h42, 1'b0, 1'b1, 24'h040406, 16'h4242, 1'b0);
    // BG scroll double write with the low byte from the latch
    addRow(paWr, 24'h00210D, 8'h0D, 8'h34, 1'b0, 1'b1, 24'h04051A, 16'h3400, 1'b1);
    addRow(paWr, 24'h00210D, 8'h0D, 8'h12, 1'b0, 1'b1, 24'h04051A, 16'h1234, 1'b1);
    // PPU status read, ignored address, stalled WRAM write
    addRow(paRd, 24'h00213C, 8'h3C, 8'h5E, 1'b0, 1'b1, 24'h040578, 16'h5E5E, 1'b1);
    addRow(cpuWr, 24'h004000, 8'hFF, 8'h00, 1'b0, 1'b0, 24'h000000, 16'h0000, 1'b0);
    addRow(cpuWr, 24'h7F0010, 8'hFF, 8'hC3, 1'b1, 1'b1, 24'h010010, 16'hC3C3, 1'b0);
  endtask

  // ----------------------------------------
  // one table row through setup, strobe and handshake
  // ----------------------------------------
  task automatic runRow(input int idx);
    int holdLen;
    int errorsBefore;
    holdLen = 0;
    errorsBefore = errorCount;
    curRow = idx;
    if (rowStall[idx]) holdLen = 2 + ($unsigned($random(seed)) % 4);
    @(posedge clkin);
    #2;
    snesAddr = rowAddr[idx];
    snesPa = rowPa[idx];
    snesData = rowData[idx];
    busRdy = (holdLen == 0);
    @(posedge clkin);
    #2;
    wrStrobe = (rowKind[idx] == cpuWr);
    paWrStrobe = (rowKind[idx] == paWr);
    paRdStrobe = (rowKind[idx] == paRd);
    @(posedge clkin);
    #2;
    wrStrobe = 1'b0;
    paWrStrobe = 1'b0;
    paRdStrobe = 1'b0;
    #5;
    if (!expReq[idx]) begin
      checkFlag(busWrq, 1'b0, "busWrq without a mirrored access");
    end else begin
      repeat (holdLen) begin
        checkFlag(busWrq, 1'b0, "busWrq while busRdy low");
        checkAddr(romAddr, mirrorBase + expOffset[idx], "stalled romAddr");
        @(posedge clkin);
        #7;
      end
      if (holdLen > 0) begin
        @(posedge clkin);
        #2;
        busRdy = 1'b1;
        #5;
      end
      checkFlag(busWrq, 1'b1, "busWrq");
      checkAddr(romAddr, mirrorBase + expOffset[idx], "romAddr");
      checkData(romData, expData[idx], "romData");
      checkFlag(romWordEnable, expWord[idx], "romWordEnable");
      @(posedge clkin);
      #7;
      checkFlag(busWrq, 1'b0, "busWrq held past one cycle");
    end
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("row %0d passed", idx);
    end else begin
      $display("row %0d had %0d errors", idx, errorCount - errorsBefore);
    end
  endtask

  initial begin
    reset = 1'b1;
    snesAddr = '0;
    snesPa = 8'hFF;
    snesData = '0;
    wrStrobe = 1'b0;
    paRdStrobe = 1'b0;
    paWrStrobe = 1'b0;
    busRdy = 1'b1;
    buildTable();
    repeat (5) @(posedge clkin);
    #2;
    reset = 1'b0;
    for (int i = 0; i < rowCount; i++) begin
      runRow(i);
    end
    $display("rows %0d, passed %0d, check errors %0d", rowCount, passCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* rtl/contextSnoop.sv */
`timescale 1ns/1ps

module contextSnoop #(
  parameter snoopPkg::busAddrT mirrorBase = 24'hF50000
) (
  input  logic              clkin,
  input  logic              reset,
  input  snoopPkg::busAddrT snesAddr,
  input  snoopPkg::byteT    snesPa,
  input  snoopPkg::byteT    snesData,
  input  logic              wrStrobe,
  input  logic              paRdStrobe,
  input  logic              paWrStrobe,
  input  logic              busRdy,
  output logic              busWrq,
  output snoopPkg::busAddrT romAddr,
  output snoopPkg::romDataT romData,
  output logic              romWordEnable
);

  logic               wramPortHit;
  logic               vramHit;
  logic               cgramHit;
  logic               oamHit;
  logic               bgDouble;
  logic               m7Double;
  snoopPkg::targetT   target;
  snoopPkg::wramPtrT  wramPtr;
  logic [16:0]        vramOffset;
  snoopPkg::cgramPtrT cgramPtr;
  snoopPkg::oamPtrT   oamPtr;

  // ----------------------------------------
  // pointer trackers
  // ----------------------------------------
  wramTracker wramTracker_inst (
    .clkin(clkin), .reset(reset), .snesPa(snesPa), .snesData(snesData),
    .paRdStrobe(paRdStrobe), .paWrStrobe(paWrStrobe),
    .wramPortHit(wramPortHit), .wramPtr(wramPtr)
  );

  vramTracker vramTracker_inst (
    .clkin(clkin), .reset(reset), .snesPa(snesPa), .snesData(snesData),
    .paRdStrobe(paRdStrobe), .paWrStrobe(paWrStrobe),
    .vramHit(vramHit), .vramOffset(vramOffset)
  );

  paletteSpriteTracker paletteSpriteTracker_inst (
    .clkin(clkin), .reset(reset), .snesPa(snesPa), .snesData(snesData),
    .paRdStrobe(paRdStrobe), .paWrStrobe(paWrStrobe),
    .cgramHit(cgramHit), .oamHit(oamHit), .cgramPtr(cgramPtr), .oamPtr(oamPtr)
  );

  // target selection and SRAM request
  accessDecode accessDecode_inst (
    .clkin(clkin), .reset(reset), .snesAddr(snesAddr), .snesPa(snesPa),
    .wrStrobe(wrStrobe), .paRdStrobe(paRdStrobe), .paWrStrobe(paWrStrobe),
    .wramPortHit(wramPortHit), .vramHit(vramHit), .cgramHit(cgramHit),
    .oamHit(oamHit), .target(target), .bgDouble(bgDouble), .m7Double(m7Double)
  );

  mirrorRequest #(.mirrorBase(mirrorBase)) mirrorRequest_inst (
    .clkin(clkin), .reset(reset), .target(target), .bgDouble(bgDouble),
    .m7Double(m7Double), .snesAddr(snesAddr), .snesPa(snesPa), .snesData(snesData),
    .wramPtr(wramPtr), .vramOffset(vramOffset), .cgramPtr(cgramPtr), .oamPtr(oamPtr),
    .busRdy(busRdy), .busWrq(busWrq), .romAddr(romAddr), .romData(romData),
    .romWordEnable(romWordEnable)
  );

endmodule

/* rtl/mirrorRequest.sv */
`timescale 1ns/1ps

module mirrorRequest #(
  parameter snoopPkg::busAddrT mirrorBase = 24'hF50000
) (
  input  logic               clkin,
  input  logic               reset,
  input  snoopPkg::targetT   target,
  input  logic               bgDouble,
  input  logic               m7Double,
  input  snoopPkg::busAddrT  snesAddr,
  input  snoopPkg::byteT     snesPa,
  input  snoopPkg::byteT     snesData,
  input  snoopPkg::wramPtrT  wramPtr,
  input  logic [16:0]        vramOffset,
  input  snoopPkg::cgramPtrT cgramPtr,
  input  snoopPkg::oamPtrT   oamPtr,
  input  logic               busRdy,
  output logic               busWrq,
  output snoopPkg::busAddrT  romAddr,
  output snoopPkg::romDataT  romData,
  output logic               romWordEnable
);

  snoopPkg::busAddrT regionBase;
  snoopPkg::busAddrT inRegion;
  snoopPkg::busAddrT reqAddr;
  snoopPkg::byteT    bgLatch;
  snoopPkg::byteT    m7Latch;
  snoopPkg::byteT    lowByte;
  logic              newHit;
  logic              isWord;
  logic              reqPending;

  // ----------------------------------------
  // SRAM address
  // ----------------------------------------
  always_comb begin
    case (target)
      snoopPkg::tgtWramShadow: begin
        regionBase = snoopPkg::wramOffset;
        inRegion   = snoopPkg::busAddrT'(snesAddr[12:0]);
      end
      snoopPkg::tgtWramBank: begin
        regionBase = snoopPkg::wramOffset;
        inRegion   = snoopPkg::busAddrT'(snesAddr[16:0]);
      end
      snoopPkg::tgtWramPort: begin
        regionBase = snoopPkg::wramOffset;
        inRegion   = snoopPkg::busAddrT'(wramPtr);
      end
      snoopPkg::tgtVram: begin
        regionBase = snoopPkg::vramOffset;
        inRegion   = snoopPkg::busAddrT'(vramOffset);
      end
      snoopPkg::tgtCgram: begin
        regionBase = snoopPkg::cgramOffset;
        inRegion   = snoopPkg::busAddrT'(cgramPtr);
      end
      snoopPkg::tgtOam: begin
        regionBase = snoopPkg::oamOffset;
        // 32-byte high table repeats
        inRegion   = snoopPkg::busAddrT'(oamPtr[9] ? (oamPtr & 10'h21F) : oamPtr);
      end
      snoopPkg::tgtPpuReg: begin
        regionBase = snoopPkg::ppuRegOffset;
        inRegion   = snoopPkg::busAddrT'({snesPa, 1'b0});
      end
      default: begin
        regionBase = snoopPkg::idleOffset;
        inRegion   = '0;
      end
    endcase
  end

  assign reqAddr = mirrorBase + regionBase + inRegion;
  assign newHit  = (target != snoopPkg::tgtNone);
  assign isWord  = (target == snoopPkg::tgtPpuReg);

  // low byte of a double write comes from the previous write
  // BG latch wins over M7
  assign lowByte = bgDouble ? bgLatch : (m7Double ? m7Latch : snesData);

  always_ff @(posedge clkin) begin
    if (reset) begin
      bgLatch <= '0;
      m7Latch <= '0;
    end else begin
      if (bgDouble) bgLatch <= snesData;
      if (m7Double) m7Latch <= snesData;
    end
  end

  // ----------------------------------------
  // request register
  // ----------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      reqPending <= 1'b0;
    end else if (newHit) begin
      reqPending <= 1'b1;
    end else if (busRdy) begin
      reqPending <= 1'b0;
    end
  end

  always_ff @(posedge clkin) begin
    if (newHit) begin
      romAddr       <= reqAddr;
      romData       <= {snesData, isWord ? lowByte : snesData};
      romWordEnable <= isWord;
    end
  end

  assign busWrq = reqPending && busRdy;

  // double-write latches only serve PPU register words
  assert property (@(posedge clkin) disable iff (reset)
    (bgDouble || m7Double) |-> (target == snoopPkg::tgtPpuReg));

endmodule

/* rtl/paletteSpriteTracker.sv */
`timescale 1ns/1ps

module paletteSpriteTracker (
  input  logic               clkin,
  input  logic               reset,
  input  snoopPkg::byteT     snesPa,
  input  snoopPkg::byteT     snesData,
  input  logic               paRdStrobe,
  input  logic               paWrStrobe,
  output logic               cgramHit,
  output logic               oamHit,
  output snoopPkg::cgramPtrT cgramPtr,
  output snoopPkg::oamPtrT   oamPtr
);

  logic cgramPortR;
  logic oamPortR;

  always_ff @(posedge clkin) begin
    if (reset) begin
      cgramPortR <= 1'b0;
      oamPortR   <= 1'b0;
    end else begin
      cgramPortR <= (snesPa == snoopPkg::regCgramData);
      oamPortR   <= (snesPa == snoopPkg::regOamData);
    end
  end

  // ----------------------------------------
  // palette pointer, byte granular
  // ----------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      cgramPtr <= '0;
    end else if (paWrStrobe && (snesPa == snoopPkg::regCgramAddr)) begin
      cgramPtr <= {snesData, 1'b0};
    end else if ((paWrStrobe && (snesPa == snoopPkg::regCgramData)) ||
                 (paRdStrobe && (snesPa == snoopPkg::regCgramRead))) begin
      cgramPtr <= cgramPtr + 1'b1;
    end
  end

  // ----------------------------------------
  // sprite pointer, bit 9 selects high table
  // ----------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      oamPtr <= '0;
    end else if (paWrStrobe && (snesPa == snoopPkg::regOamAddrLo)) begin
      oamPtr <= {oamPtr[9], snesData, 1'b0};
    end else if (paWrStrobe && (snesPa == snoopPkg::regOamAddrHi)) begin
      oamPtr <= {snesData[0], oamPtr[8:1], 1'b0};
    end else if ((paWrStrobe && (snesPa == snoopPkg::regOamData)) ||
                 (paRdStrobe && (snesPa == snoopPkg::regOamRead))) begin
      oamPtr <= oamPtr + 1'b1;
    end
  end

  assign cgramHit = paWrStrobe && cgramPortR;
  assign oamHit   = paWrStrobe && oamPortR;

endmodule

/* rtl/vramTracker.sv */
`timescale 1ns/1ps

module vramTracker (
  input  logic           clkin,
  input  logic           reset,
  input  snoopPkg::byteT snesPa,
  input  snoopPkg::byteT snesData,
  input  logic           paRdStrobe,
  input  logic           paWrStrobe,
  output logic           vramHit,
  output logic [16:0]    vramOffset
);

  snoopPkg::byteT    vramMode;
  snoopPkg::vramPtrT vramPtr;
  snoopPkg::vramPtrT stepSize;
  snoopPkg::vramPtrT remapPtr;
  logic              dataPortR;
  logic              stepLo;
  logic              stepHi;

  // ----------------------------------------
  // pointer step
  // ----------------------------------------
  always_comb begin
    case (vramMode[1:0])
      2'd0:    stepSize = 16'd1;
      2'd1:    stepSize = 16'd32;
      default: stepSize = 16'd128;
    endcase
  end

  assign stepLo = (paWrStrobe && (snesPa == snoopPkg::regVramDataLo)) ||
                  (paRdStrobe && (snesPa == snoopPkg::regVramReadLo));
  assign stepHi = (paWrStrobe && (snesPa == snoopPkg::regVramDataHi)) ||
                  (paRdStrobe && (snesPa == snoopPkg::regVramReadHi));

  always_ff @(posedge clkin) begin
    if (reset) begin
      dataPortR <= 1'b0;
      vramMode  <= '0;
      vramPtr   <= '0;
    end else begin
      dataPortR <= (snesPa == snoopPkg::regVramDataLo) ||
                   (snesPa == snoopPkg::regVramDataHi);
      if (paWrStrobe && (snesPa == snoopPkg::regVramMode)) vramMode <= snesData;
      if (paWrStrobe && (snesPa == snoopPkg::regVramAddrLo)) begin
        vramPtr[7:0] <= snesData;
      end else if (paWrStrobe && (snesPa == snoopPkg::regVramAddrHi)) begin
        vramPtr[15:8] <= snesData;
      end else if (vramMode[7] ? stepHi : stepLo) begin
        // mode bit 7 picks which half of the word steps
        vramPtr <= vramPtr + stepSize;
      end
    end
  end

  // address translation rotates the low 8/9/10 bits
  always_comb begin
    case (vramMode[3:2])
      2'd0:    remapPtr = vramPtr;
      2'd1:    remapPtr = {vramPtr[15:8], vramPtr[4:0], vramPtr[7:5]};
      2'd2:    remapPtr = {vramPtr[15:9], vramPtr[5:0], vramPtr[8:6]};
      default: remapPtr = {vramPtr[15:10], vramPtr[6:0], vramPtr[9:7]};
    endcase
  end

  assign vramOffset = {remapPtr, snesPa[0]};
  assign vramHit    = paWrStrobe && dataPortR;

  // data port number stays on the bus through the strobe
  assert property (@(posedge clkin) disable iff (reset)
    vramHit |-> ((snesPa == snoopPkg::regVramDataLo) ||
                 (snesPa == snoopPkg::regVramDataHi)));

endmodule

/* rtl/wramTracker.sv */
`timescale 1ns/1ps

module wramTracker (
  input  logic              clkin,
  input  logic              reset,
  input  snoopPkg::byteT    snesPa,
  input  snoopPkg::byteT    snesData,
  input  logic              paRdStrobe,
  input  logic              paWrStrobe,
  output logic              wramPortHit,
  output snoopPkg::wramPtrT wramPtr
);

  logic dataPortR;
  logic portAccess;

  // any access to the data port advances the pointer
  assign portAccess = (paRdStrobe || paWrStrobe) && dataPortR;

  always_ff @(posedge clkin) begin
    if (reset) begin
      dataPortR <= 1'b0;
      wramPtr   <= '0;
    end else begin
      dataPortR <= (snesPa == snoopPkg::regWramData);
      if (paWrStrobe && (snesPa == snoopPkg::regWramAddrLo)) begin
        wramPtr[7:0] <= snesData;
      end else if (paWrStrobe && (snesPa == snoopPkg::regWramAddrMid)) begin
        wramPtr[15:8] <= snesData;
      end else if (paWrStrobe && (snesPa == snoopPkg::regWramAddrHi)) begin
        // only bit 0 matters, 128 KiB of WRAM
        wramPtr[16] <= snesData[0];
      end else if (portAccess) begin
        wramPtr <= wramPtr + 1'b1;
      end
    end
  end

  // reads of the port are not mirrored
  assign wramPortHit = paWrStrobe && dataPortR;

endmodule

/* rtl/accessDecode.sv */
`timescale 1ns/1ps

module accessDecode (
  input  logic              clkin,
  input  logic              reset,
  input  snoopPkg::busAddrT snesAddr,
  input  snoopPkg::byteT    snesPa,
  input  logic              wrStrobe,
  input  logic              paRdStrobe,
  input  logic              paWrStrobe,
  input  logic              wramPortHit,
  input  logic              vramHit,
  input  logic              cgramHit,
  input  logic              oamHit,
  output snoopPkg::targetT  target,
  output logic              bgDouble,
  output logic              m7Double
);

  logic shadowAddr;
  logic bankAddr;
  logic ppuWrAddr;
  logic ppuRdAddr;
  logic shadowFlagR;
  logic bankFlagR;
  logic ppuWrFlagR;
  logic ppuRdFlagR;
  logic bgFlagR;
  logic m7FlagR;

  // ----------------------------------------
  // address classes, one cycle ahead
  // ----------------------------------------
  // banks $00-$3F/$80-$BF below $2000
  assign shadowAddr = !snesAddr[22] && (snesAddr[15:13] == 3'd0);
  // banks $7E-$7F
  assign bankAddr = (snesAddr[23:17] == 7'h3F);

  // everything up to $33 except the data ports, plus WRAM pointer regs
  assign ppuWrAddr = ((snesPa <= 8'h33) && (snesPa != snoopPkg::regOamData) &&
                      (snesPa != snoopPkg::regVramDataLo) &&
                      (snesPa != snoopPkg::regVramDataHi) &&
                      (snesPa != snoopPkg::regCgramData)) ||
                     (snesPa == snoopPkg::regWramAddrLo) ||
                     (snesPa == snoopPkg::regWramAddrMid) ||
                     (snesPa == snoopPkg::regWramAddrHi);
  assign ppuRdAddr = ((snesPa >= 8'h34) && (snesPa <= 8'h36)) ||
                     ((snesPa >= 8'h3C) && (snesPa <= 8'h3F));

  always_ff @(posedge clkin) begin
    if (reset) begin
      shadowFlagR <= 1'b0;
      bankFlagR   <= 1'b0;
      ppuWrFlagR  <= 1'b0;
      ppuRdFlagR  <= 1'b0;
      bgFlagR     <= 1'b0;
      m7FlagR     <= 1'b0;
    end else begin
      shadowFlagR <= shadowAddr;
      bankFlagR   <= bankAddr;
      ppuWrFlagR  <= ppuWrAddr;
      ppuRdFlagR  <= ppuRdAddr;
      // scroll regs $0D-$14, mode 7 regs $0D-$0E and $1B-$20
      bgFlagR     <= (snesPa >= 8'h0D) && (snesPa <= 8'h14);
      m7FlagR     <= ((snesPa >= 8'h0D) && (snesPa <= 8'h0E)) ||
                     ((snesPa >= 8'h1B) && (snesPa <= 8'h20));
    end
  end

  // fixed priority, WRAM first
  always_comb begin
    if (wrStrobe && shadowFlagR) target = snoopPkg::tgtWramShadow;
    else if (wrStrobe && bankFlagR) target = snoopPkg::tgtWramBank;
    else if (wramPortHit) target = snoopPkg::tgtWramPort;
    else if (vramHit) target = snoopPkg::tgtVram;
    else if (cgramHit) target = snoopPkg::tgtCgram;
    else if (oamHit) target = snoopPkg::tgtOam;
    else if ((paWrStrobe && ppuWrFlagR) || (paRdStrobe && ppuRdFlagR))
      target = snoopPkg::tgtPpuReg;
    else target = snoopPkg::tgtNone;
  end

  assign bgDouble = paWrStrobe && bgFlagR;
  assign m7Double = paWrStrobe && m7FlagR;

  // bus cycles never overlap
  assert property (@(posedge clkin) disable iff (reset)
    $onehot0({wrStrobe, paRdStrobe, paWrStrobe}));

endmodule

/* rtl/snoopPkg.sv */
package snoopPkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  typedef logic [23:0] busAddrT;
  typedef logic [7:0]  byteT;
  typedef logic [15:0] romDataT;
  typedef logic [16:0] wramPtrT;
  typedef logic [15:0] vramPtrT;
  typedef logic [8:0]  cgramPtrT;
  typedef logic [9:0]  oamPtrT;

  // which mirror region a bus access lands in
  typedef enum logic [2:0] {
    tgtNone,
    tgtWramShadow,
    tgtWramBank,
    tgtWramPort,
    tgtVram,
    tgtCgram,
    tgtOam,
    tgtPpuReg
  } targetT;

  // ----------------------------------------
  // mirror layout, relative to mirror base
  // ----------------------------------------
  localparam busAddrT wramOffset   = 24'h000000;
  localparam busAddrT vramOffset   = 24'h020000;
  localparam busAddrT cgramOffset  = 24'h040000;
  localparam busAddrT oamOffset    = 24'h040200;
  localparam busAddrT ppuRegOffset = 24'h040500;
  localparam busAddrT idleOffset   = 24'h048000;

  // B-bus port numbers
  localparam byteT regOamAddrLo   = 8'h02;
  localparam byteT regOamAddrHi   = 8'h03;
  localparam byteT regOamData     = 8'h04;
  localparam byteT regVramMode    = 8'h15;
  localparam byteT regVramAddrLo  = 8'h16;
  localparam byteT regVramAddrHi  = 8'h17;
  localparam byteT regVramDataLo  = 8'h18;
  localparam byteT regVramDataHi  = 8'h19;
  localparam byteT regCgramAddr   = 8'h21;
  localparam byteT regCgramData   = 8'h22;
  localparam byteT regOamRead     = 8'h38;
  localparam byteT regVramReadLo  = 8'h39;
  localparam byteT regVramReadHi  = 8'h3A;
  localparam byteT regCgramRead   = 8'h3B;
  localparam byteT regWramData    = 8'h80;
  localparam byteT regWramAddrLo  = 8'h81;
  localparam byteT regWramAddrMid = 8'h82;
  localparam byteT regWramAddrHi  = 8'h83;

endpackage
